// ==== logic/candRegPkg.sv ====
//////////////////////////////////////////////////////////////////////
// Register map of the clock-and-data sampler.
// Region placement, register offsets and control field positions,
// shared by the bus decoder and the control register block.
//////////////////////////////////////////////////////////////////////

`default_nettype none

package candRegPkg;

    // Region of 16 words starting at 13'h0400.
    localparam logic [12:0] RegionBase = 13'h0400;
    localparam logic [12:0] RegionMask = 13'h1ff0;   // Upper bits select the region.

    // Word offsets inside the region.
    localparam logic [12:0] CtrlOffset  = 13'd0;     // Control, read/write.
    localparam logic [12:0] DataOffset  = 13'd1;     // Last packed word, read only.
    localparam logic [12:0] CountOffset = 13'd2;     // Word count, read only.

    // Control field positions.
    // Each field sits in its own byte lane.
    localparam int SourceLsb = 0;     // Source select in bits 2:0, lane 0.
    localparam int PhaseLsb  = 8;     // Sample phase in bits 9:8, lane 1.
    localparam int ResetBit  = 31;    // Sampler reset, lane 3.

endpackage

`default_nettype wire

// ==== logic/candDataPkg.sv ====
//////////////////////////////////////////////////////////////////////
// Data types of the sampling path.
// Source index, sample phase, packed word and the oversample ratio.
//////////////////////////////////////////////////////////////////////

`default_nettype none

package candDataPkg;

    typedef logic [2:0]  sourceSel;   // Serial input index.
    typedef logic [1:0]  phaseSel;    // Sample phase within a bit.
    typedef logic [31:0] dataWord;    // Packed word, MSB first.

    // busClk cycles per bit, set by the width of phaseSel.
    localparam int OversampleRatio = 4;

endpackage

`default_nettype wire

// ==== logic/regBus.sv ====
//////////////////////////////////////////////////////////////////////
// Internal register bus between the decoder and the register blocks.
// Carries one-hot selects, byte enables, write data and readback.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

interface regBus;
    import candDataPkg::*;

    logic       ctrlSel;       // Control register selected.
    logic       dataSel;       // Last word register selected.
    logic       countSel;      // Word count register selected.
    logic [3:0] wrByte;        // Byte lane write enables, region gated.
    dataWord    wrData;
    dataWord    ctrlRdData;    // Control readback word.
    dataWord    lastWord;      // Last complete word.
    logic [31:0] wordCount;

    modport decoder (output ctrlSel, dataSel, countSel, wrByte, wrData,
                     input ctrlRdData, lastWord, wordCount);
    modport ctrl    (input ctrlSel, wrByte, wrData, output ctrlRdData);
    modport status  (output lastWord, wordCount);

endinterface

`default_nettype wire

// ==== logic/busDecode.sv ====
//////////////////////////////////////////////////////////////////////
// Bus front end of the sampler.
// Matches the address against the register region, produces the
// register selects and gated byte enables, and muxes read data.
// Reads are combinational and return zero outside mapped registers.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module busDecode (
    input  wire logic [12:0]         addr,
    input  wire candDataPkg::dataWord dataIn,
    input  wire logic                wr0,
    input  wire logic                wr1,
    input  wire logic                wr2,
    input  wire logic                wr3,
    output candDataPkg::dataWord     dataOut,
    regBus.decoder                   bus
);
    import candRegPkg::*;

    logic        inRegion;
    logic [12:0] offset;

    assign inRegion = ((addr & RegionMask) == RegionBase);
    assign offset   = addr & ~RegionMask;    // Word offset within the region.

    // One-hot selects, only inside the region.
    assign bus.ctrlSel  = inRegion && (offset == CtrlOffset);
    assign bus.dataSel  = inRegion && (offset == DataOffset);
    assign bus.countSel = inRegion && (offset == CountOffset);

    // Strobes outside the region never reach the registers.
    assign bus.wrByte = inRegion ? {wr3, wr2, wr1, wr0} : 4'b0000;
    assign bus.wrData = dataIn;

    // Read mux.
    // Unmapped offsets and foreign addresses read zero.
    always_comb begin
        if (bus.ctrlSel) begin
            dataOut = bus.ctrlRdData;
        end else if (bus.dataSel) begin
            dataOut = bus.lastWord;
        end else if (bus.countSel) begin
            dataOut = bus.wordCount;
        end else begin
            dataOut = '0;
        end
    end

endmodule

`default_nettype wire

// ==== logic/candRegs.sv ====
//////////////////////////////////////////////////////////////////////
// Control register of the sampler.
// Byte lane writes set source, clkPhase and clkReset. The fields
// drive the sampler directly and are read back in one word.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module candRegs (
    input  wire logic                 busClk,
    input  wire logic                 rst,
    regBus.ctrl                       bus,
    output candDataPkg::sourceSel     source,
    output candDataPkg::phaseSel      clkPhase,
    output logic                      clkReset
);
    import candRegPkg::*;
    import candDataPkg::*;

    // Each field has its own lane.
    // Lane 2 is unused.
    always_ff @(posedge busClk) begin
        if (rst) begin
            source   <= '0;
            clkPhase <= '0;
            clkReset <= 1'b0;
        end else if (bus.ctrlSel) begin
            if (bus.wrByte[0]) begin
                source <= bus.wrData[SourceLsb +: $bits(sourceSel)];    // Lane 0.
            end
            if (bus.wrByte[1]) begin
                clkPhase <= bus.wrData[PhaseLsb +: $bits(phaseSel)];    // Lane 1.
            end
            if (bus.wrByte[3]) begin
                clkReset <= bus.wrData[ResetBit];                       // Lane 3.
            end
        end
    end

    // Readback word.
    // Bits without a field are zero.
    always_comb begin
        bus.ctrlRdData = '0;
        bus.ctrlRdData[SourceLsb +: $bits(sourceSel)] = source;
        bus.ctrlRdData[PhaseLsb +: $bits(phaseSel)]   = clkPhase;
        bus.ctrlRdData[ResetBit]                      = clkReset;
    end

endmodule

`default_nettype wire

// ==== logic/dataSampler.sv ====
//////////////////////////////////////////////////////////////////////
// Serial input sampler.
// Picks one of the serial inputs, synchronizes it to busClk and
// samples it once per bit period at the programmed phase.
// clkReset holds the phase counter and suppresses samples.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module dataSampler #(
    parameter int NumSources = 8    // 2 to 8 serial inputs.
) (
    input  wire logic                  busClk,
    input  wire logic                  rst,
    input  wire logic [NumSources-1:0] serialIn,
    input  wire candDataPkg::sourceSel source,
    input  wire candDataPkg::phaseSel  clkPhase,
    input  wire logic                  clkReset,
    output logic                       sampleBit,
    output logic                       sampleValid
);
    import candDataPkg::*;

    logic       selBit;
    logic [1:0] syncFf;      // Two-flop synchronizer.
    phaseSel    phaseCnt;    // Position within the bit period.
    logic       runQ;        // Low for the first cycle after rst.

    // Indexes past the last input read as zero.
    assign selBit = (int'(source) < NumSources) ? serialIn[source] : 1'b0;

    always_ff @(posedge busClk) begin
        if (rst) begin
            syncFf <= 2'b00;
        end else begin
            syncFf <= {syncFf[0], selBit};
        end
    end

    // Phase counter.
    // Held at zero in reset, then wraps every bit period.
    always_ff @(posedge busClk) begin
        if (rst || clkReset) begin
            phaseCnt <= '0;
        end else if (phaseCnt == phaseSel'(OversampleRatio - 1)) begin
            phaseCnt <= '0;
        end else begin
            phaseCnt <= phaseCnt + 1'b1;
        end
    end

    always_ff @(posedge busClk) begin
        if (rst) begin
            runQ <= 1'b0;
        end else begin
            runQ <= 1'b1;
        end
    end

    // One strobe per bit at the chosen phase.
    assign sampleValid = runQ && !clkReset && (phaseCnt == clkPhase);
    assign sampleBit   = syncFf[1];    // Synchronized bit of this cycle.

endmodule

`default_nettype wire

// ==== logic/wordPacker.sv ====
//////////////////////////////////////////////////////////////////////
// Word packer of the sampler.
// Shifts samples in MSB first and latches every complete 32-bit
// word with a running word count for the status registers.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module wordPacker (
    input  wire logic busClk,
    input  wire logic rst,
    input  wire logic clkReset,
    input  wire logic sampleBit,
    input  wire logic sampleValid,
    regBus.status     bus
);
    import candDataPkg::*;

    localparam int CntBits = $clog2($bits(dataWord));

    dataWord            shiftReg;    // Partial word.
    logic [CntBits-1:0] bitCnt;      // Bits held in shiftReg.
    dataWord            nextWord;

    assign nextWord = {shiftReg[$bits(dataWord)-2:0], sampleBit};

    // Partial word and alignment.
    // clkReset discards a word cut short.
    always_ff @(posedge busClk) begin
        if (rst || clkReset) begin
            shiftReg <= '0;
            bitCnt   <= '0;
        end else if (sampleValid) begin
            shiftReg <= nextWord;
            bitCnt   <= bitCnt + 1'b1;    // Wraps to zero after the last bit.
        end
    end

    // Completed words survive clkReset.
    always_ff @(posedge busClk) begin
        if (rst) begin
            bus.lastWord  <= '0;
            bus.wordCount <= '0;
        end else if (!clkReset && sampleValid && (&bitCnt)) begin
            bus.lastWord  <= nextWord;                 // 32nd sample.
            bus.wordCount <= bus.wordCount + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== logic/candTop.sv ====
//////////////////////////////////////////////////////////////////////
// Top level of the clock-and-data sampling front end.
// Register bus and serial inputs in, read data out. NumSources sets
// the number of serial inputs and is passed to the sampler.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module candTop #(
    parameter int NumSources = 8
) (
    input  wire logic                  busClk,
    input  wire logic                  rst,
    input  wire logic [12:0]           addr,
    input  wire logic [31:0]           dataIn,
    input  wire logic                  wr0,
    input  wire logic                  wr1,
    input  wire logic                  wr2,
    input  wire logic                  wr3,
    output logic      [31:0]           dataOut,
    input  wire logic [NumSources-1:0] serialIn
);
    import candDataPkg::*;

    sourceSel source;
    phaseSel  clkPhase;
    logic     clkReset;     // Also realigns the packer.
    logic     sampleBit;
    logic     sampleValid;

    regBus bus0 ();

    busDecode decode0 (
        .addr    (addr),
        .dataIn  (dataIn),
        .wr0     (wr0),
        .wr1     (wr1),
        .wr2     (wr2),
        .wr3     (wr3),
        .dataOut (dataOut),
        .bus     (bus0)
    );

    candRegs regs0 (
        .busClk   (busClk),
        .rst      (rst),
        .bus      (bus0),
        .source   (source),
        .clkPhase (clkPhase),
        .clkReset (clkReset)
    );

    dataSampler #(.NumSources(NumSources)) sampler0 (
        .busClk      (busClk),
        .rst         (rst),
        .serialIn    (serialIn),
        .source      (source),
        .clkPhase    (clkPhase),
        .clkReset    (clkReset),
        .sampleBit   (sampleBit),
        .sampleValid (sampleValid)
    );

    wordPacker packer0 (
        .busClk      (busClk),
        .rst         (rst),
        .clkReset    (clkReset),
        .sampleBit   (sampleBit),
        .sampleValid (sampleValid),
        .bus         (bus0)
    );

endmodule

`default_nettype wire

// ==== verification/candTb_assert.sv ====
//////////////////////////////////////////////////////////////////////
// Assertions on the sampler strobe and the word count.
// Bound into candTop from the testbench.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module candAssert (
    input wire logic        busClk,
    input wire logic        rst,
    input wire logic        clkReset,
    input wire logic        sampleValid,
    input wire logic [31:0] wordCount
);

    logic [2:0] resetHist;    // clkReset over the last three cycles.
    logic [3:0] validHist;    // sampleValid over the last four cycles.

    always_ff @(posedge busClk) begin
        if (rst) begin
            resetHist <= '0;
            validHist <= '0;
        end else begin
            resetHist <= {resetHist[1:0], clkReset};
            validHist <= {validHist[2:0], sampleValid};
        end
    end

    noSampleInHold: assert property (@(posedge busClk) disable iff (rst)
        clkReset |-> !sampleValid)
        else $error("sampleValid high while clkReset is high");

    // No closer pulses while the sampler runs.
    sampleSpacing: assert property (@(posedge busClk) disable iff (rst)
        (sampleValid && resetHist == 3'b000) |-> validHist[2:0] == 3'b000)
        else $error("sampleValid pulses closer than four cycles");

    samplePeriod: assert property (@(posedge busClk) disable iff (rst)
        (validHist[3] && resetHist == 3'b000 && !clkReset) |-> sampleValid)
        else $error("sampleValid missing four cycles after the last pulse");

    countMonotonic: assert property (@(posedge busClk) disable iff (rst)
        wordCount >= $past(wordCount))
        else $error("wordCount decreased without rst");

endmodule

`default_nettype wire

// ==== verification/candTb.sv ====
//////////////////////////////////////////////////////////////////////
// Testbench of the clock-and-data sampling front end.
// Checks register access and decode, then runs a table of source,
// phase and pattern entries through the sampler and reads back DATA.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module candTb;

    localparam int NumSources = 8;
    localparam int NumEntries = 8;
    localparam int CycleLimit = NumEntries * 150 + 200;    // About 135 per entry, setup under 200.

    localparam logic [12:0] CtrlAddr  = 13'h0400;
    localparam logic [12:0] DataAddr  = 13'h0401;
    localparam logic [12:0] CountAddr = 13'h0402;

    logic                  busClk;
    logic                  rst;
    logic [12:0]           addr;
    logic [31:0]           dataIn;
    logic                  wr0;
    logic                  wr1;
    logic                  wr2;
    logic                  wr3;
    logic [31:0]           dataOut;
    logic [NumSources-1:0] serialIn;

    int          errors;
    int          testsRun;
    int          testsFailed;
    int          cycles = 0;
    logic [31:0] noise;    // Xorshift state.

    // Stimulus table, one entry per sampling test.
    string       testName    [8] = '{"src0ph0", "src1ph1", "src2ph2", "src3ph3",
                                     "src4ph0", "src5ph1", "src6ph2", "src7ph3"};
    logic [2:0]  testSrc     [8] = '{3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd6, 3'd7};
    logic [1:0]  testPhase   [8] = '{2'd0, 2'd1, 2'd2, 2'd3, 2'd0, 2'd1, 2'd2, 2'd3};
    logic [31:0] testPattern [8] = '{32'h8000_0001, 32'ha5a5_5a5a, 32'hffff_0000,
                                     32'h0000_ffff, 32'h1234_5678, 32'hdead_beef,
                                     32'h7fff_fffe, 32'hc3c3_3c3c};
    // Read-only, unmapped and foreign addresses.
    logic [12:0] deadAddr    [5] = '{13'h0401, 13'h0402, 13'h0405, 13'h0410, 13'h1400};

    candTop #(.NumSources(NumSources)) dut0 (
        .busClk   (busClk),
        .rst      (rst),
        .addr     (addr),
        .dataIn   (dataIn),
        .wr0      (wr0),
        .wr1      (wr1),
        .wr2      (wr2),
        .wr3      (wr3),
        .dataOut  (dataOut),
        .serialIn (serialIn)
    );

    bind candTop candAssert assert0 (
        .busClk      (busClk),
        .rst         (rst),
        .clkReset    (clkReset),
        .sampleValid (sampleValid),
        .wordCount   (bus0.wordCount)
    );

    always #20 busClk = ~busClk;    // 40 ns period.

    always @(posedge busClk) begin
        cycles = cycles + 1;
        if (cycles >= CycleLimit) begin
            $display("Run stopped after %0d cycles, the DUT never finished", cycles);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    function automatic logic [31:0] nextRandom(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Called at edge plus 2 ns, returns at the next one.
    task automatic writeReg(input logic [12:0] a, input logic [31:0] d, input logic [3:0] lanes);
        addr   = a;
        dataIn = d;
        {wr3, wr2, wr1, wr0} = lanes;
        @(posedge busClk);
        #2;
        {wr3, wr2, wr1, wr0} = 4'b0000;    // One-cycle strobe.
    endtask

    task automatic readReg(input logic [12:0] a, output logic [31:0] d);
        addr = a;
        #5;
        d = dataOut;    // Combinational read, settled.
        @(posedge busClk);
        #2;
    endtask

    task automatic checkValue(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("Fail %s: expected %h, actual %h", what, expected, actual);
        end
    endtask

    task automatic reportTest(input string what, input int errBefore);
        testsRun++;
        if (errors > errBefore) begin
            testsFailed++;
            $display("test %s: failed", what);
        end else begin
            $display("test %s: ok", what);
        end
    endtask

    task automatic driveNoise(input int n);
        repeat (n) begin
            noise    = nextRandom(noise);
            serialIn = noise[NumSources-1:0];
            @(posedge busClk);
            #2;
        end
    endtask

    task automatic runEntry(input logic [2:0] i);
        int          errBefore;
        int          c;
        int          tries;
        logic [4:0]  bitIdx;
        logic [31:0] value;
        logic [31:0] expCount;
        errBefore = errors;
        expCount  = 32'(i) + 32'd1;    // One word per entry.
        writeReg(CtrlAddr, {1'b1, 21'd0, testPhase[i], 5'd0, testSrc[i]}, 4'b1111);
        // Bit k leads bit period k by two cycles, the synchronizer latency.
        for (c = 0; c < 128; c++) begin
            bitIdx   = 5'(31 - c / 4);
            noise    = nextRandom(noise);
            serialIn = noise[NumSources-1:0];    // Noise on the other inputs.
            serialIn[testSrc[i]] = testPattern[i][bitIdx];
            if (c == 1) begin
                writeReg(CtrlAddr, 32'h0000_0000, 4'b1000);    // Counter zero follows.
            end else begin
                @(posedge busClk);
                #2;
            end
        end
        tries = 0;
        readReg(CountAddr, value);
        while (value != expCount && tries < 8) begin    // Wait for the word.
            readReg(CountAddr, value);
            tries++;
        end
        checkValue({testName[i], " count"}, expCount, value);
        readReg(DataAddr, value);
        checkValue(testName[i], testPattern[i], value);
        reportTest(testName[i], errBefore);
    endtask

    initial begin
        logic [31:0] value;
        int          errBefore;
        logic [2:0]  k;
        busClk   = 1'b0;
        rst      = 1'b1;
        addr     = '0;
        dataIn   = '0;
        wr0      = 1'b0;
        wr1      = 1'b0;
        wr2      = 1'b0;
        wr3      = 1'b0;
        serialIn = '0;
        errors      = 0;
        testsRun    = 0;
        testsFailed = 0;
        noise       = 32'hf5e4_ef17;
        repeat (2) @(posedge busClk);
        #2;
        rst = 1'b0;

        errBefore = errors;
        readReg(CtrlAddr, value);
        checkValue("ctrlReset ctrl", 32'h0, value);
        readReg(DataAddr, value);
        checkValue("ctrlReset data", 32'h0, value);
        readReg(CountAddr, value);
        checkValue("ctrlReset count", 32'h0, value);
        reportTest("ctrlReset", errBefore);

        errBefore = errors;
        writeReg(CtrlAddr, 32'h8000_0105, 4'b1111);    // Held, source 5, phase 1.
        readReg(CtrlAddr, value);
        checkValue("laneWrite all", 32'h8000_0105, value);
        writeReg(CtrlAddr, 32'h7fff_ffff, 4'b0010);    // Phase lane only.
        readReg(CtrlAddr, value);
        checkValue("laneWrite wr1", 32'h8000_0305, value);
        writeReg(CtrlAddr, 32'h7fff_fcfa, 4'b0100);    // Lane 2 has no field.
        readReg(CtrlAddr, value);
        checkValue("laneWrite wr2", 32'h8000_0305, value);
        reportTest("laneWrite", errBefore);

        errBefore = errors;
        for (k = 0; k < 5; k++) begin
            writeReg(deadAddr[k], 32'hffff_ffff, 4'b1111);
            readReg(deadAddr[k], value);
            checkValue("decode dead", 32'h0, value);
        end
        readReg(CtrlAddr, value);
        checkValue("decode ctrl", 32'h8000_0305, value);
        reportTest("decode", errBefore);

        // Partial word, then a hold longer than one word.
        errBefore = errors;
        writeReg(CtrlAddr, 32'h0, 4'b1111);
        driveNoise(32);
        writeReg(CtrlAddr, 32'h8000_0000, 4'b1000);
        driveNoise(132);
        readReg(CountAddr, value);
        checkValue("hold count", 32'h0, value);
        reportTest("hold", errBefore);

        for (int i = 0; i < NumEntries; i++) begin
            runEntry(3'(i));
        end

        $display("tests run %0d, failed %0d, mismatches %0d", testsRun, testsFailed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
logic/candRegPkg.sv
logic/candDataPkg.sv
logic/regBus.sv
logic/busDecode.sv
logic/candRegs.sv
logic/dataSampler.sv
logic/wordPacker.sv
logic/candTop.sv
verification/candTb_assert.sv
verification/candTb.sv

// ==== Makefile ====
TOP = candTb

all: run

run:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f sources.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q '^PASS: all tests$$'

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f sources.f

clean:
	rm -rf obj_dir

.PHONY: all run lint clean
